// File: sources.f
hw/lcd_pkg.sv
hw/lcd_bus_cycle.sv
hw/lcd_init_seq.sv
hw/lcd_ctrl.sv
hw/lcd_text_writer.sv
hw/lcd_top.sv
dv/lcd_monitor.sv
dv/tb_lcd_top.sv

// File: dv/tb_lcd_top.sv
`timescale 1ns/1ps

module tb_lcd_top import lcd_pkg::*; ();

	typedef enum logic [1:0] {k_char, k_cmd, k_ignored} row_kind_e;

	typedef struct packed {
		row_kind_e    kind;
		logic [12:0]  value; // lcd_char_t, or lcd_word_t in the low bits
		logic [127:0] name;
	} stim_row_t;

	localparam int n_rows = 10;
	localparam int timeout_cyc = t_power_cyc + 4 * t_cycle_cyc + t_clear_extra_cyc
		+ t_entry_extra_cyc + n_rows * 2 * t_cycle_cyc + 1000;

	logic         clk;
	logic         rst;
	lcd_config_t  cfg;
	logic         char_strobe;
	lcd_char_t    char_in;
	logic         cmd_strobe;
	lcd_word_t    cmd_in;
	lcd_pins_t    pins;
	logic         busy;
	logic         exp_strobe;
	lcd_word_t    exp_word;
	logic [127:0] exp_name;
	int           mon_errors;
	int           words_seen;
	int           pending;
	int           stim_errors;
	int           cycles = 0;
	logic [6:0]   pred_addr; // cursor as the tb expects it
	logic         pred_valid;
	stim_row_t    rows[n_rows];

	lcd_top dut (
		.clk         (clk),
		.rst         (rst),
		.cfg         (cfg),
		.char_strobe (char_strobe),
		.char_in     (char_in),
		.cmd_strobe  (cmd_strobe),
		.cmd_in      (cmd_in),
		.pins        (pins),
		.busy        (busy)
	);

	lcd_monitor u_monitor (
		.clk        (clk),
		.rst        (rst),
		.pins       (pins),
		.busy       (busy),
		.exp_strobe (exp_strobe),
		.exp_word   (exp_word),
		.exp_name   (exp_name),
		.errors     (mon_errors),
		.words_seen (words_seen),
		.pending    (pending)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= timeout_cyc) begin
			$display("timeout: the run did not finish within %0d cycles", timeout_cyc);
			$display("Verification failed");
			$finish;
		end
	end

	task automatic load_table();
		rows[0] = '{k_char, {1'b0, 4'd0, "H"}, "first_char"};
		rows[1] = '{k_char, {1'b0, 4'd1, "i"}, "next_col"};
		rows[2] = '{k_ignored, {1'b1, 4'd15, "Z"}, "busy_strobe"}; // must vanish
		rows[3] = '{k_char, {1'b0, 4'd5, "!"}, "col_jump"};
		rows[4] = '{k_char, {1'b1, 4'd0, "A"}, "line2"};
		rows[5] = '{k_char, {1'b1, 4'd1, "B"}, "line2_next"};
		rows[6] = '{k_cmd, 13'h002, "raw_home"};
		rows[7] = '{k_char, {1'b1, 4'd2, "C"}, "after_cmd"};
		rows[8] = '{k_cmd, 13'h00c, "raw_disp"};
		rows[9] = '{k_char, {1'b0, 4'd0, "x"}, "after_cmd2"};
	endtask

	task automatic push_expected(input lcd_word_t w, input logic [127:0] name);
		exp_word = w;
		exp_name = name;
		exp_strobe = 1'b1;
		@(negedge clk);
		exp_strobe = 1'b0;
	endtask

	function automatic lcd_word_t init_cmd(input int idx);
		lcd_word_t w;
		w = '0;
		case (idx)
			0: w.data = {4'b0011, cfg.display_lines, cfg.font, 2'b00}; // function set
			1: w.data = {5'b00001, cfg.display_on, cfg.cursor, cfg.blink};
			2: w.data = 8'h01; // clear
			default: w.data = {6'b000001, cfg.inc_dec, cfg.shift};
		endcase
		return w;
	endfunction

	task automatic expect_row(input stim_row_t row);
		lcd_char_t  ch;
		lcd_word_t  w;
		logic [6:0] addr;
		ch = row.value;
		if (row.kind == k_cmd) begin
			w = row.value[9:0];
			push_expected(w, row.name);
			pred_valid = 1'b0;
		end else begin
			addr = 7'(line2_base * ch.line) + 7'(ch.col);
			if (!pred_valid || addr != pred_addr) begin
				w = '0;
				w.data = 8'h80 + addr;
				push_expected(w, row.name);
			end
			w = '0;
			w.rs = 1'b1;
			w.data = ch.code;
			push_expected(w, row.name);
			pred_addr = cfg.inc_dec ? addr + 7'd1 : addr - 7'd1;
			pred_valid = 1'b1;
		end
	endtask

	task automatic wait_idle();
		while (busy) @(negedge clk);
	endtask

	initial begin
		int i;
		int total;
		rst = 1'b1;
		char_strobe = 1'b0;
		char_in = '0;
		cmd_strobe = 1'b0;
		cmd_in = '0;
		exp_strobe = 1'b0;
		exp_word = '0;
		exp_name = '0;
		stim_errors = 0;
		pred_addr = '0;
		pred_valid = 1'b0;
		cfg = '{display_lines: 1'b1, font: 1'b0, display_on: 1'b1, cursor: 1'b1,
			blink: 1'b0, inc_dec: 1'b1, shift: 1'b0};
		load_table();
		repeat (2) @(negedge clk);
		rst = 1'b0;
		push_expected(init_cmd(0), "init_func");
		push_expected(init_cmd(1), "init_disp");
		push_expected(init_cmd(2), "init_clear");
		push_expected(init_cmd(3), "init_entry");
		for (i = 0; i < n_rows; i++) begin
			if (rows[i].kind == k_ignored) begin
				repeat (2) @(negedge clk); // writer idle, controller still busy
				if (!busy) begin
					$display("ERROR: busy already low when row %0s was applied", rows[i].name);
					stim_errors++;
				end
				char_in = rows[i].value;
				char_strobe = 1'b1;
			end else begin
				wait_idle();
				expect_row(rows[i]);
				if (rows[i].kind == k_char) begin
					char_in = rows[i].value;
					char_strobe = 1'b1;
				end else begin
					cmd_in = rows[i].value[9:0];
					cmd_strobe = 1'b1;
				end
			end
			@(negedge clk);
			char_strobe = 1'b0;
			cmd_strobe = 1'b0;
		end
		wait_idle();
		repeat (4) @(negedge clk);
		total = mon_errors + stim_errors + pending;
		$display("summary: %0d words, %0d monitor errors, %0d stimulus errors, %0d words missing",
			words_seen, mon_errors, stim_errors, pending);
		if (total == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

// File: dv/lcd_monitor.sv
`timescale 1ns/1ps

module lcd_monitor import lcd_pkg::*; (
	input  logic         clk,
	input  logic         rst,
	input  lcd_pins_t    pins,
	input  logic         busy,
	input  logic         exp_strobe,
	input  lcd_word_t    exp_word,
	input  logic [127:0] exp_name,
	output int           errors,
	output int           words_seen,
	output int           pending
);

	localparam int unsigned e_width = t_e_fall_cyc - t_e_rise_cyc;
	// enable rises one microsecond into the cycle
	localparam int unsigned settle_min = t_cycle_cyc + t_entry_extra_cyc - t_e_rise_cyc;

	lcd_word_t    exp_q[$];
	logic [127:0] name_q[$];
	int           run_cyc; // clocks since reset release
	int           rise_cyc;
	int           rises;
	int unsigned  min_gap;
	logic         e_prev;
	logic         init_seen; // busy has fallen once
	lcd_word_t    got;

	initial begin
		errors = 0;
		words_seen = 0;
		pending = 0;
		run_cyc = 0;
		rise_cyc = 0;
		rises = 0;
		e_prev = 1'b0;
		init_seen = 1'b0;
	end

	always @(posedge clk) begin
		if (exp_strobe) begin
			exp_q.push_back(exp_word);
			name_q.push_back(exp_name);
		end
		if (rst) begin
			run_cyc <= 0;
		end else begin
			run_cyc <= run_cyc + 1;
		end
	end

	task automatic check_word(input lcd_word_t act);
		lcd_word_t    exp;
		logic [127:0] name;
		words_seen = words_seen + 1;
		if (exp_q.size() == 0) begin
			$display("ERROR: transfer %h arrived with no expected word", act);
			errors = errors + 1;
		end else begin
			exp = exp_q.pop_front();
			name = name_q.pop_front();
			if (act !== exp) begin
				$display("FAILED %0s: expected %h, actual %h", name, exp, act);
				errors = errors + 1;
			end
		end
	endtask

	always @(negedge clk) begin
		if (run_cyc > 0) begin
			if (pins.e && !e_prev) begin
				if (run_cyc < t_power_cyc) begin
					$display("ERROR: enable pulse during the power-up wait, cycle %0d", run_cyc);
					errors = errors + 1;
				end
				min_gap = t_cycle_cyc;
				if (words_seen == 3) begin
					min_gap = t_cycle_cyc + t_clear_extra_cyc; // after clear
				end else if (words_seen == 4) begin
					min_gap = t_cycle_cyc + t_entry_extra_cyc; // after entry mode
				end
				if (rises > 0 && run_cyc - rise_cyc < min_gap) begin
					$display("ERROR: enable rises only %0d cycles apart, need %0d",
						run_cyc - rise_cyc, min_gap);
					errors = errors + 1;
				end
				rise_cyc = run_cyc;
				rises = rises + 1;
			end
			if (!pins.e && e_prev) begin
				if (run_cyc - rise_cyc != e_width) begin
					$display("ERROR: enable high for %0d cycles instead of %0d",
						run_cyc - rise_cyc, e_width);
					errors = errors + 1;
				end
				got.rs = pins.rs; // data still on the pins at the fall
				got.rw = pins.rw;
				got.data = pins.data;
				check_word(got);
			end
			if (!busy && !init_seen) begin
				init_seen = 1'b1;
				if (words_seen != 4) begin
					$display("ERROR: busy fell after %0d init words instead of 4", words_seen);
					errors = errors + 1;
				end
				if (run_cyc - rise_cyc < settle_min) begin
					$display("ERROR: busy fell before the entry mode settle wait ended");
					errors = errors + 1;
				end
			end
			e_prev = pins.e;
		end
		pending = exp_q.size();
	end

endmodule

// File: hw/lcd_top.sv
`timescale 1ns/1ps

module lcd_top import lcd_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  lcd_config_t cfg, // held stable
	input  logic        char_strobe,
	input  lcd_char_t   char_in,
	input  logic        cmd_strobe,
	input  lcd_word_t   cmd_in,
	output lcd_pins_t   pins,
	output logic        busy
);

	logic      ctrl_busy;
	logic      word_strobe;
	lcd_word_t word;

	// busy already includes ctrl_busy
	lcd_text_writer u_writer (
		.clk         (clk),
		.rst         (rst),
		.cfg         (cfg),
		.char_strobe (char_strobe),
		.char_in     (char_in),
		.cmd_strobe  (cmd_strobe),
		.cmd_in      (cmd_in),
		.ctrl_busy   (ctrl_busy),
		.busy        (busy),
		.word_strobe (word_strobe),
		.word        (word)
	);

	lcd_ctrl u_ctrl (
		.clk         (clk),
		.rst         (rst),
		.cfg         (cfg),
		.word_strobe (word_strobe),
		.word        (word),
		.ctrl_busy   (ctrl_busy),
		.pins        (pins)
	);

endmodule

// File: hw/lcd_text_writer.sv
`timescale 1ns/1ps

module lcd_text_writer import lcd_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  lcd_config_t cfg,
	input  logic        char_strobe,
	input  lcd_char_t   char_in,
	input  logic        cmd_strobe,
	input  lcd_word_t   cmd_in,
	input  logic        ctrl_busy,
	output logic        busy,
	output logic        word_strobe,
	output lcd_word_t   word
);

	writer_state_e state;
	logic [6:0]    tgt_addr; // ddram address of the incoming char
	logic [6:0]    addr_q;
	logic [7:0]    code_q;
	lcd_word_t     cmd_q;
	logic [6:0]    pred_addr;
	logic          pred_valid;
	logic          taken;

	assign tgt_addr = char_in.line ? (line2_base + 7'(char_in.col)) : 7'(char_in.col);

	assign busy = (state != wr_idle) || ctrl_busy;
	assign word_strobe = (state != wr_idle); // held until the controller takes it
	assign taken = word_strobe && !ctrl_busy;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= wr_idle;
			pred_addr <= '0;
			pred_valid <= 1'b0;
		end else begin
			case (state)
				wr_idle: begin
					if (char_strobe && !busy) begin
						// skip the address write when the cursor is already there
						if (pred_valid && pred_addr == tgt_addr) begin
							state <= wr_data;
						end else begin
							state <= wr_addr;
						end
					end else if (cmd_strobe && !busy) begin
						state <= wr_cmd;
					end
				end
				wr_addr: if (taken) state <= wr_data;
				wr_data: begin
					if (taken) begin
						state <= wr_idle;
						pred_addr <= cfg.inc_dec ? addr_q + 7'd1 : addr_q - 7'd1;
						pred_valid <= 1'b1;
					end
				end
				wr_cmd: begin
					if (taken) begin
						state <= wr_idle;
						pred_valid <= 1'b0; // raw command may move the cursor
					end
				end
				default: state <= wr_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == wr_idle && !busy) begin
			addr_q <= tgt_addr;
			code_q <= char_in.code;
			cmd_q <= cmd_in;
		end
	end

	always_comb begin
		word = '0;
		case (state)
			wr_addr: word.data = {1'b1, addr_q}; // set ddram address
			wr_data: begin
				word.rs = 1'b1;
				word.data = code_q;
			end
			wr_cmd: word = cmd_q;
			default: word = '0;
		endcase
	end

endmodule

// File: hw/lcd_ctrl.sv
`timescale 1ns/1ps

module lcd_ctrl import lcd_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  lcd_config_t cfg,
	input  logic        word_strobe,
	input  lcd_word_t   word,
	output logic        ctrl_busy,
	output lcd_pins_t   pins
);

	ctrl_state_e         state;
	logic [cnt_bits-1:0] pwr_cnt;
	logic                pwr_end;
	logic                init_go;
	logic                init_strobe;
	lcd_word_t           init_word;
	logic                init_complete;
	logic                accept; // writer word taken this cycle
	logic                start;
	lcd_word_t           cyc_word;
	logic                done;

	assign pwr_end = (pwr_cnt == cnt_bits'(t_power_cyc - 1));
	assign init_go = (state == st_power) && pwr_end;
	assign accept = (state == st_idle) && word_strobe;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_power;
			pwr_cnt <= '0;
		end else begin
			case (state)
				st_power: begin
					pwr_cnt <= pwr_cnt + 1'b1;
					if (pwr_end) begin
						state <= st_init;
					end
				end
				st_init: begin
					if (init_complete) begin
						state <= st_idle;
					end
				end
				st_idle: begin
					if (accept) begin
						state <= st_xfer;
					end
				end
				st_xfer: begin
					if (done) begin
						state <= st_idle;
					end
				end
				default: state <= st_power;
			endcase
		end
	end

	assign ctrl_busy = (state != st_idle);

	// init sequencer owns the engine until it completes
	assign start = (state == st_init) ? init_strobe : accept;
	assign cyc_word = (state == st_init) ? init_word : word;

	lcd_init_seq u_init_seq (
		.clk           (clk),
		.rst           (rst),
		.init_go       (init_go),
		.cfg           (cfg),
		.done          (done),
		.init_strobe   (init_strobe),
		.init_word     (init_word),
		.init_complete (init_complete)
	);

	lcd_bus_cycle u_bus_cycle (
		.clk   (clk),
		.rst   (rst),
		.start (start),
		.word  (cyc_word),
		.pins  (pins),
		.done  (done)
	);

endmodule

// File: hw/lcd_init_seq.sv
`timescale 1ns/1ps

module lcd_init_seq import lcd_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  logic        init_go,
	input  lcd_config_t cfg,
	input  logic        done,
	output logic        init_strobe,
	output lcd_word_t   init_word,
	output logic        init_complete
);

	init_step_e          step;
	init_step_e          step_next;
	logic                issue; // strobe the current step's command
	logic                settling;
	logic [cnt_bits-1:0] settle_cnt;
	logic [cnt_bits-1:0] settle_len;
	logic                settle_end;

	always_comb begin
		case (step)
			step_func: step_next = step_disp;
			step_disp: step_next = step_clear;
			step_clear: step_next = step_entry;
			default: step_next = step_done;
		endcase
	end

	// only clear and entry mode need the longer wait
	assign settle_len = (step == step_clear) ? cnt_bits'(t_clear_extra_cyc - 1)
		: cnt_bits'(t_entry_extra_cyc - 1);
	assign settle_end = settling && (settle_cnt == settle_len);

	always_ff @(posedge clk) begin
		if (rst) begin
			step <= step_func;
			issue <= 1'b0;
			settling <= 1'b0;
			settle_cnt <= '0;
		end else begin
			issue <= 1'b0;
			if (init_go) begin
				step <= step_func;
				issue <= 1'b1;
			end else if (done && !settling && step != step_done) begin
				if (step == step_clear || step == step_entry) begin
					settling <= 1'b1;
					settle_cnt <= '0;
				end else begin
					step <= step_next;
					issue <= 1'b1;
				end
			end else if (settle_end) begin
				settling <= 1'b0;
				step <= step_next;
				issue <= (step_next != step_done);
			end else if (settling) begin
				settle_cnt <= settle_cnt + 1'b1;
			end
		end
	end

	always_comb begin
		init_word = '0; // rs and rw stay zero for all init commands
		case (step)
			step_func: init_word.data = {4'b0011, cfg.display_lines, cfg.font, 2'b00};
			step_disp: init_word.data = {5'b00001, cfg.display_on, cfg.cursor, cfg.blink};
			step_clear: init_word.data = 8'b0000_0001;
			step_entry: init_word.data = {6'b000001, cfg.inc_dec, cfg.shift};
			default: init_word.data = 8'h00;
		endcase
	end

	assign init_strobe = issue;
	assign init_complete = (step == step_done);

endmodule

// File: hw/lcd_bus_cycle.sv
`timescale 1ns/1ps

module lcd_bus_cycle import lcd_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  logic      start,
	input  lcd_word_t word,
	output lcd_pins_t pins,
	output logic      done
);

	logic                active; // a transfer is on the pins
	logic [cnt_bits-1:0] cnt; // clocks since the cycle began
	lcd_word_t           word_q;
	logic                e_on;

	always_ff @(posedge clk) begin
		if (rst) begin
			active <= 1'b0;
			cnt <= '0;
		end else if (start) begin
			active <= 1'b1; // restart also allowed on the done cycle
			cnt <= '0;
		end else if (done) begin
			active <= 1'b0;
			cnt <= '0;
		end else if (active) begin
			cnt <= cnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			word_q <= word;
		end
	end

	assign done = active && (cnt == cnt_bits'(t_cycle_cyc - 1));

	// enable high for cnt in [rise, fall), i.e. 13 us
	assign e_on = active
		&& (cnt >= cnt_bits'(t_e_rise_cyc))
		&& (cnt < cnt_bits'(t_e_fall_cyc));

	always_comb begin
		pins = '0; // bus parked at zero between transfers
		if (active) begin
			pins.e = e_on;
			pins.rs = word_q.rs;
			pins.rw = word_q.rw;
			pins.data = word_q.data;
		end
	end

endmodule

// File: hw/lcd_pkg.sv
package lcd_pkg;

	// timing base, 4 for simulation
	localparam int unsigned clk_per_us = 4;

	localparam int unsigned t_power_us = 500;
	localparam int unsigned t_cycle_us = 50; // one bus transfer
	localparam int unsigned t_e_rise_us = 1;
	localparam int unsigned t_e_fall_us = 14;
	localparam int unsigned t_clear_extra_us = 150;
	localparam int unsigned t_entry_extra_us = 50;
	localparam int unsigned cnt_bits = 12; // must hold the power-up count

	// same values in clocks
	localparam int unsigned t_power_cyc = t_power_us * clk_per_us;
	localparam int unsigned t_cycle_cyc = t_cycle_us * clk_per_us;
	localparam int unsigned t_e_rise_cyc = t_e_rise_us * clk_per_us;
	localparam int unsigned t_e_fall_cyc = t_e_fall_us * clk_per_us;
	localparam int unsigned t_clear_extra_cyc = t_clear_extra_us * clk_per_us;
	localparam int unsigned t_entry_extra_cyc = t_entry_extra_us * clk_per_us;

	localparam logic [6:0] line2_base = 7'h40; // ddram start of line 2

	typedef struct packed {
		logic display_lines;
		logic font;
		logic display_on;
		logic cursor;
		logic blink;
		logic inc_dec;
		logic shift;
	} lcd_config_t;

	typedef struct packed {
		logic       rs;
		logic       rw;
		logic [7:0] data;
	} lcd_word_t;

	typedef struct packed {
		logic       line;
		logic [3:0] col;
		logic [7:0] code;
	} lcd_char_t;

	typedef struct packed {
		logic       e;
		logic       rs;
		logic       rw;
		logic [7:0] data;
	} lcd_pins_t;

	typedef enum logic [1:0] {st_power, st_init, st_idle, st_xfer} ctrl_state_e;

	typedef enum logic [2:0] {
		step_func,
		step_disp,
		step_clear,
		step_entry,
		step_done
	} init_step_e;

	typedef enum logic [1:0] {wr_idle, wr_addr, wr_data, wr_cmd} writer_state_e;

endpackage
